// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_port \
  -f tb.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

// ==== source/cmd_issue.sv ====
// Request queue, issue gating, byte-enable masking and memory request drive
`timescale 1ns/100ps

module cmd_issue (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  req_if.sink                             req_i,
  input  logic                            descriptor_valid_i,
  input  logic                            response_ready_i,
  output logic                            request_prog_full_o,
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output logic [mem_port_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [mem_port_pkg::DATA_W-1:0] mem_wdata_o,
  output logic [mem_port_pkg::STRB_W-1:0] mem_be_o,
  input  logic                            mem_gnt_i,
  issue_if.issuer                         iss_o
);

  logic [mem_port_pkg::REQ_ENTRY_W-1:0] req_din;
  logic [mem_port_pkg::REQ_ENTRY_W-1:0] req_dout;
  logic                                 req_empty;
  logic                                 grant;
  logic [mem_port_pkg::CMD_W-1:0]       head_cmd;
  logic [mem_port_pkg::ADDR_W-1:0]      head_addr;
  logic [mem_port_pkg::DATA_W-1:0]      head_wdata;
  logic [mem_port_pkg::STRB_W-1:0]      head_strb;
  logic [mem_port_pkg::TAG_W-1:0]       head_tag;
  logic                                 head_is_write;

  // --------------------------------------------------
  // Request queue, FWFT
  // --------------------------------------------------
  assign req_din = {req_i.cmd, req_i.addr, req_i.wdata, req_i.strb, req_i.tag};

  sync_fifo #(
    .WIDTH      (mem_port_pkg::REQ_ENTRY_W),
    .DEPTH      (mem_port_pkg::REQ_DEPTH),
    .PROG_THRESH(mem_port_pkg::REQ_PROG_THRESH)
  ) u_req_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_i        (req_i.valid),
    .din_i         (req_din),
    .pop_i         (grant),              // Leaves the queue on grant
    .dout_o        (req_dout),
    .empty_o       (req_empty),
    .full_o        (),
    .prog_full_o   (request_prog_full_o) // Sender back-pressure
  );

  assign {head_cmd, head_addr, head_wdata, head_strb, head_tag} = req_dout;

  // --------------------------------------------------
  // Issue gating and memory drive
  // --------------------------------------------------
  assign mem_req_o     = ~req_empty & descriptor_valid_i & ~iss_o.pend_prog_full
                         & response_ready_i;
  assign head_is_write = (head_cmd == mem_port_pkg::CMD_MEM_WRITE);
  assign mem_we_o      = head_is_write;
  assign mem_addr_o    = head_addr;
  assign mem_wdata_o   = head_wdata;
  assign mem_be_o      = head_strb & {mem_port_pkg::STRB_W{head_is_write}}; // Zero on reads
  assign grant         = mem_req_o & mem_gnt_i;

  // Grant report, pending queue pushes on the same edge
  assign iss_o.grant     = grant;
  assign iss_o.cmd       = head_cmd;
  assign iss_o.tag       = head_tag;
  assign iss_o.req_empty = req_empty;

  // Held request keeps its address until granted, unless ready drops
  a_req_held : assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_req_o && !mem_gnt_i) |=> (!response_ready_i || (mem_req_o && $stable(mem_addr_o))))
    else $error("mem_req_o dropped or address changed before grant");

endmodule : cmd_issue

// ==== source/issue_if.sv ====
// Grant events and queue status between the issue stage and the response merge
`timescale 1ns/100ps

interface issue_if;

  // --------------------------------------------------
  // Issue to merge
  // --------------------------------------------------
  logic                           grant;     // One cycle, request taken by memory
  logic [mem_port_pkg::CMD_W-1:0] cmd;       // Command of the granted request
  logic [mem_port_pkg::TAG_W-1:0] tag;       // Tag of the granted request
  logic                           req_empty; // Request queue empty, for done

  // --------------------------------------------------
  // Merge to issue
  // --------------------------------------------------
  logic                           pend_prog_full; // Too many outstanding

  // Request queue owner
  modport issuer (
    output grant, cmd, tag, req_empty,
    input  pend_prog_full
  );

  // Pending queue owner
  modport merger (
    input  grant, cmd, tag, req_empty,
    output pend_prog_full
  );

endinterface : issue_if

// ==== source/mem_port_pkg.sv ====
// Widths, queue depths, programmable-full levels and command codes of the memory port
package mem_port_pkg;

  // --------------------------------------------------
  // Data path widths
  // --------------------------------------------------
  localparam int ADDR_W   = 32;         // Byte address toward memory
  localparam int OFFSET_W = 24;         // Word offset given by the kernel
  localparam int DATA_W   = 32;         // One memory word
  localparam int STRB_W   = DATA_W / 8; // One enable per byte
  localparam int TAG_W    = 8;          // Opaque tag, returned unchanged
  localparam int CMD_W    = 2;

  // Bytes per word as a shift amount
  localparam int WORD_SHIFT = 2;

  // --------------------------------------------------
  // Command codes
  // --------------------------------------------------
  localparam logic [CMD_W-1:0] CMD_MEM_READ  = 2'd1;
  localparam logic [CMD_W-1:0] CMD_MEM_WRITE = 2'd2;

  // --------------------------------------------------
  // Queue sizing
  // --------------------------------------------------
  // Request queue, prog full warns the sender early
  localparam int REQ_DEPTH       = 16;
  localparam int REQ_PROG_THRESH = 12;

  // Pending queue holds granted but unanswered commands
  localparam int PEND_DEPTH       = 16;
  localparam int PEND_PROG_THRESH = 8;  // Stops new issues

  // --------------------------------------------------
  // Packed queue entries
  // --------------------------------------------------
  // Request entry  {cmd, addr, wdata, strb, tag}
  localparam int REQ_ENTRY_W = CMD_W + ADDR_W + DATA_W + STRB_W + TAG_W;

  // Pending entry  {cmd, tag}
  localparam int PEND_ENTRY_W = CMD_W + TAG_W;

endpackage : mem_port_pkg

// ==== source/mem_port_top.sv ====
// Memory port front end top level, ingress, issue and response merge on plain ports
`timescale 1ns/100ps

module mem_port_top (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  // Kernel descriptor
  input  logic                              descriptor_valid_i,
  input  logic [mem_port_pkg::ADDR_W-1:0]   descriptor_base_i,
  // Requests from the compute unit
  input  logic                              request_valid_i,
  input  logic [mem_port_pkg::CMD_W-1:0]    request_cmd_i,
  input  logic [mem_port_pkg::OFFSET_W-1:0] request_offset_i,
  input  logic [mem_port_pkg::DATA_W-1:0]   request_wdata_i,
  input  logic [mem_port_pkg::STRB_W-1:0]   request_strb_i,
  input  logic [mem_port_pkg::TAG_W-1:0]    request_tag_i,
  output logic                              request_prog_full_o,
  // Responses to the compute unit
  output logic                              response_valid_o,
  output logic [mem_port_pkg::CMD_W-1:0]    response_cmd_o,
  output logic [mem_port_pkg::TAG_W-1:0]    response_tag_o,
  output logic [mem_port_pkg::DATA_W-1:0]   response_rdata_o,
  input  logic                              response_ready_i,
  // Memory request/grant port
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [mem_port_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [mem_port_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [mem_port_pkg::STRB_W-1:0]   mem_be_o,
  input  logic                              mem_gnt_i,
  input  logic                              mem_rsp_valid_i,
  input  logic [mem_port_pkg::DATA_W-1:0]   mem_rsp_rdata_i,
  output logic                              done_o
);

  logic descriptor_valid;  // Latched in ingress, gates issue

  // --------------------------------------------------
  // Internal buses
  // --------------------------------------------------
  req_if   req_bus ();
  issue_if iss_bus ();

  req_ingress u_req_ingress (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .descriptor_valid_i(descriptor_valid_i),
    .descriptor_base_i (descriptor_base_i),
    .request_valid_i   (request_valid_i),
    .request_cmd_i     (request_cmd_i),
    .request_offset_i  (request_offset_i),
    .request_wdata_i   (request_wdata_i),
    .request_strb_i    (request_strb_i),
    .request_tag_i     (request_tag_i),
    .descriptor_valid_o(descriptor_valid),
    .req_o             (req_bus.src)
  );

  cmd_issue u_cmd_issue (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .req_i              (req_bus.sink),
    .descriptor_valid_i (descriptor_valid),
    .response_ready_i   (response_ready_i),
    .request_prog_full_o(request_prog_full_o),
    .mem_req_o          (mem_req_o),
    .mem_we_o           (mem_we_o),
    .mem_addr_o         (mem_addr_o),
    .mem_wdata_o        (mem_wdata_o),
    .mem_be_o           (mem_be_o),
    .mem_gnt_i          (mem_gnt_i),
    .iss_o              (iss_bus.issuer)
  );

  rsp_merge u_rsp_merge (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .iss_i           (iss_bus.merger),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .response_valid_o(response_valid_o),
    .response_cmd_o  (response_cmd_o),
    .response_tag_o  (response_tag_o),
    .response_rdata_o(response_rdata_o),
    .done_o          (done_o)
  );

endmodule : mem_port_top

// ==== source/req_if.sv ====
// Formed memory request bus from the ingress pipeline to the issue stage
`timescale 1ns/100ps

interface req_if;

  // --------------------------------------------------
  // Request fields
  // --------------------------------------------------
  logic                              valid; // Push strobe, one cycle per request
  logic [mem_port_pkg::CMD_W-1:0]    cmd;   // Read or write
  logic [mem_port_pkg::ADDR_W-1:0]   addr;  // Byte address, base already added
  logic [mem_port_pkg::DATA_W-1:0]   wdata;
  logic [mem_port_pkg::STRB_W-1:0]   strb;  // Raw strobe, masked at issue
  logic [mem_port_pkg::TAG_W-1:0]    tag;

  // No ready here
  // Sender is held off through the request prog full flag

  // Ingress side
  modport src (
    output valid, cmd, addr, wdata, strb, tag
  );

  // Issue side
  modport sink (
    input valid, cmd, addr, wdata, strb, tag
  );

endinterface : req_if

// ==== source/req_ingress.sv ====
// Descriptor latch and two-stage request pipeline forming byte addresses
`timescale 1ns/100ps

module req_ingress (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              descriptor_valid_i,
  input  logic [mem_port_pkg::ADDR_W-1:0]   descriptor_base_i,
  input  logic                              request_valid_i,
  input  logic [mem_port_pkg::CMD_W-1:0]    request_cmd_i,
  input  logic [mem_port_pkg::OFFSET_W-1:0] request_offset_i,
  input  logic [mem_port_pkg::DATA_W-1:0]   request_wdata_i,
  input  logic [mem_port_pkg::STRB_W-1:0]   request_strb_i,
  input  logic [mem_port_pkg::TAG_W-1:0]    request_tag_i,
  output logic                              descriptor_valid_o,
  req_if.src                                req_o
);

  logic [mem_port_pkg::ADDR_W-1:0]   base_q;      // Buffer base of the kernel
  logic                              req_valid_q;
  logic [mem_port_pkg::CMD_W-1:0]    cmd_q;
  logic [mem_port_pkg::OFFSET_W-1:0] offset_q;
  logic [mem_port_pkg::DATA_W-1:0]   wdata_q;
  logic [mem_port_pkg::STRB_W-1:0]   strb_q;
  logic [mem_port_pkg::TAG_W-1:0]    tag_q;
  logic [mem_port_pkg::ADDR_W-1:0]   byte_offset;

  // --------------------------------------------------
  // Descriptor latch, set until reset
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_valid_o <= 1'b0;
    end
    else if (descriptor_valid_i) begin
      descriptor_valid_o <= 1'b1;
      base_q             <= descriptor_base_i;
    end
  end

  // Stage 1 and stage 2 strobes
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_valid_q <= 1'b0;
      req_o.valid <= 1'b0;
    end
    else begin
      req_valid_q <= request_valid_i;
      req_o.valid <= req_valid_q;     // Push into the request queue
    end
  end

  // Zero extend, then words to bytes
  assign byte_offset = {{(mem_port_pkg::ADDR_W - mem_port_pkg::OFFSET_W){1'b0}}, offset_q}
                       << mem_port_pkg::WORD_SHIFT;

  // Payload, base taken as latched when stage 2 forms the address
  always_ff @(posedge ap_clk) begin
    {cmd_q, offset_q, wdata_q, strb_q, tag_q} <= {request_cmd_i, request_offset_i,
                                                  request_wdata_i, request_strb_i, request_tag_i};
    req_o.cmd   <= cmd_q;
    req_o.addr  <= base_q + byte_offset;
    req_o.wdata <= wdata_q;
    req_o.strb  <= strb_q;
    req_o.tag   <= tag_q;
  end

endmodule : req_ingress

// ==== source/rsp_merge.sv ====
// Pending queue, read-data capture, response forming and done flag
`timescale 1ns/100ps

module rsp_merge (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  issue_if.merger                         iss_i,
  input  logic                            mem_rsp_valid_i,
  input  logic [mem_port_pkg::DATA_W-1:0] mem_rsp_rdata_i,
  output logic                            response_valid_o,
  output logic [mem_port_pkg::CMD_W-1:0]  response_cmd_o,
  output logic [mem_port_pkg::TAG_W-1:0]  response_tag_o,
  output logic [mem_port_pkg::DATA_W-1:0] response_rdata_o,
  output logic                            done_o
);

  logic [mem_port_pkg::PEND_ENTRY_W-1:0] pend_dout;
  logic [mem_port_pkg::CMD_W-1:0]        pend_cmd;   // Oldest outstanding command
  logic [mem_port_pkg::TAG_W-1:0]        pend_tag;
  logic                                  pend_empty;
  logic                                  empty_q;    // First stage of done

  // --------------------------------------------------
  // Pending queue, one entry per grant
  // --------------------------------------------------
  sync_fifo #(
    .WIDTH      (mem_port_pkg::PEND_ENTRY_W),
    .DEPTH      (mem_port_pkg::PEND_DEPTH),
    .PROG_THRESH(mem_port_pkg::PEND_PROG_THRESH)
  ) u_pend_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_i        (iss_i.grant),
    .din_i         ({iss_i.cmd, iss_i.tag}),
    .pop_i         (mem_rsp_valid_i),     // Responses come back in grant order
    .dout_o        (pend_dout),
    .empty_o       (pend_empty),
    .full_o        (),
    .prog_full_o   (iss_i.pend_prog_full)
  );

  assign {pend_cmd, pend_tag} = pend_dout;

  // Control, done trails both queues empty by two edges
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_valid_o <= 1'b0;
      empty_q          <= 1'b1;
      done_o           <= 1'b0;
    end
    else begin
      response_valid_o <= mem_rsp_valid_i;
      empty_q          <= iss_i.req_empty & pend_empty;
      done_o           <= empty_q;
    end
  end

  // Response payload, data zeroed for writes
  always_ff @(posedge ap_clk) begin
    if (mem_rsp_valid_i) begin
      response_cmd_o   <= pend_cmd;
      response_tag_o   <= pend_tag;
      response_rdata_o <= (pend_cmd == mem_port_pkg::CMD_MEM_WRITE) ? '0 : mem_rsp_rdata_i;
    end
  end

  a_rsp_has_pending : assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_rsp_valid_i |-> !pend_empty)
    else $error("memory response without an outstanding grant");

endmodule : rsp_merge

// ==== source/sync_fifo.sv ====
// First-word-fall-through synchronous FIFO with occupancy count and programmable-full
`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH       = 8,
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             push_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] dout_o,      // Head word, valid while not empty
  output logic             empty_o,
  output logic             full_o,
  output logic             prog_full_o
);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;   // One bit wider, holds DEPTH

  logic do_push;
  logic do_pop;

  assign do_push = push_i & ~full_o;  // Overflow dropped, flagged below
  assign do_pop  = pop_i & ~empty_o;

  // Payload memory
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Pointers wrap explicitly, DEPTH need not be a power of two
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else begin
      if (do_push) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

  // Fall-through read, head seen without a pop
  assign dout_o      = mem[rd_ptr];
  assign empty_o     = (count == 0);
  assign full_o      = (count == DEPTH);
  assign prog_full_o = (count >= PROG_THRESH);

  // --------------------------------------------------
  // Checks on the users of the queue
  // --------------------------------------------------
  a_no_overflow : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(push_i && full_o))
    else $error("sync_fifo push while full");

  a_no_underflow : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(pop_i && empty_o))
    else $error("sync_fifo pop while empty");

endmodule : sync_fifo

// ==== tb.f ====
source/mem_port_pkg.sv
source/req_if.sv
source/issue_if.sv
source/sync_fifo.sv
source/req_ingress.sv
source/cmd_issue.sv
source/rsp_merge.sv
source/mem_port_top.sv
test/tb_mem_model.sv
test/tb_mem_port.sv

// ==== test/tb_mem_model.sv ====
// Memory responder model with random grant and in-order response delays
`timescale 1ns/100ps

module tb_mem_model #(
  parameter int SEED = 1
) (
  input  logic        ap_clk,
  input  logic        areset_control,
  input  logic        mem_req_i,
  input  logic        mem_we_i,
  input  logic [31:0] mem_addr_i,
  input  logic [31:0] mem_wdata_i,
  input  logic [3:0]  mem_be_i,
  output logic        mem_gnt_o,
  output logic        mem_rsp_valid_o,
  output logic [31:0] mem_rsp_rdata_o
);

  localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1; // Unwritten word is addr ^ key

  logic [31:0] store [logic [31:0]];  // Written words by byte address
  logic [31:0] rsp_data_q [$];        // Responses in grant order
  int          rsp_due_q [$];         // Cycle at which each may leave
  int          cyc;
  int          last_due;
  integer      seed;

  initial begin
    seed            = SEED;
    cyc             = 0;
    last_due        = 0;
    mem_gnt_o       = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_rdata_o = '0;
  end

  // --------------------------------------------------
  // Grant capture, then drive 1 ns after the edge
  // --------------------------------------------------
  always @(posedge ap_clk) begin
    logic [31:0] word;
    int          due;
    cyc = cyc + 1;
    if (areset_control) begin
      rsp_data_q.delete();
      rsp_due_q.delete();
      last_due = 0;
    end
    else if (mem_req_i && mem_gnt_o) begin   // Grant seen on this edge
      word = store.exists(mem_addr_i) ? store[mem_addr_i] : (mem_addr_i ^ FILL_KEY);
      if (mem_we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_be_i[b]) word[8*b +: 8] = mem_wdata_i[8*b +: 8];
        end
        store[mem_addr_i] = word;            // Write answers with the merged word
      end
      due = cyc + 1 + ($random(seed) & 3);
      if (due <= last_due) due = last_due + 1; // Keep grant order
      last_due = due;
      rsp_data_q.push_back(word);
      rsp_due_q.push_back(due);
    end
    #1;
    mem_gnt_o = !areset_control && (($random(seed) & 3) != 0);  // Random grant stalls
    if (!areset_control && rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      mem_rsp_valid_o = 1'b1;
      mem_rsp_rdata_o = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    else begin
      mem_rsp_valid_o = 1'b0;
    end
  end

endmodule : tb_mem_model

// ==== test/tb_mem_port.sv ====
// Testbench top for the memory port with clock, reset, stimulus, assertions and report
`timescale 1ns/100ps

module tb_mem_port;

  localparam int          NUM_REQ  = 60;   // 6 before descriptor, 40 random, 14 held
  localparam int          LIMIT    = 20 * NUM_REQ + 200;
  localparam logic [31:0] BASE     = 32'h8000_1000;
  localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1;

  logic ap_clk, areset_control;
  logic descriptor_valid_i, request_valid_i, response_ready_i;
  logic [31:0] descriptor_base_i, request_wdata_i;
  logic [1:0]  request_cmd_i;
  logic [23:0] request_offset_i;
  logic [3:0]  request_strb_i;
  logic [7:0]  request_tag_i;
  logic request_prog_full_o, response_valid_o, done_o;
  logic [1:0]  response_cmd_o;
  logic [7:0]  response_tag_o;
  logic [31:0] response_rdata_o, mem_addr_o, mem_wdata_o, mem_rsp_rdata;
  logic mem_req_o, mem_we_o, mem_gnt, mem_rsp_valid;
  logic [3:0]  mem_be_o;

  // Expected values, indexed in request order
  logic [31:0] exp_addr [NUM_REQ];
  logic [31:0] exp_wdata [NUM_REQ];
  logic [31:0] exp_rdata [NUM_REQ];
  logic [3:0]  exp_be [NUM_REQ];
  logic [1:0]  exp_cmd [NUM_REQ];
  logic [7:0]  exp_tag [NUM_REQ];
  logic [31:0] shadow [logic [31:0]];   // Memory image in issue order

  int     send_idx, issue_idx, rsp_idx, entered_cnt, cycles;
  int     addr_errs, data_errs, rsp_errs, ctrl_errs;
  logic   valid_d1, valid_d2, busy;
  logic   desc_given, idle_chk;
  integer seed;

  mem_port_top dut0 (
    .ap_clk(ap_clk), .areset_control(areset_control),
    .descriptor_valid_i(descriptor_valid_i), .descriptor_base_i(descriptor_base_i),
    .request_valid_i(request_valid_i), .request_cmd_i(request_cmd_i),
    .request_offset_i(request_offset_i), .request_wdata_i(request_wdata_i),
    .request_strb_i(request_strb_i), .request_tag_i(request_tag_i),
    .request_prog_full_o(request_prog_full_o),
    .response_valid_o(response_valid_o), .response_cmd_o(response_cmd_o),
    .response_tag_o(response_tag_o), .response_rdata_o(response_rdata_o),
    .response_ready_i(response_ready_i),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_be_o(mem_be_o), .mem_gnt_i(mem_gnt),
    .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_rdata_i(mem_rsp_rdata), .done_o(done_o)
  );

  tb_mem_model #(.SEED(27133)) u_mem_model (
    .ap_clk(ap_clk), .areset_control(areset_control), .mem_req_i(mem_req_o),
    .mem_we_i(mem_we_o), .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o),
    .mem_be_i(mem_be_o), .mem_gnt_o(mem_gnt), .mem_rsp_valid_o(mem_rsp_valid),
    .mem_rsp_rdata_o(mem_rsp_rdata)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // --------------------------------------------------
  // Progress counters and timeout
  // --------------------------------------------------
  assign busy = (entered_cnt != rsp_idx);  // Something queued or outstanding

  always @(posedge ap_clk) begin
    valid_d1 <= request_valid_i;
    valid_d2 <= valid_d1;                  // Queue push two edges after sampling
    if (valid_d2) entered_cnt <= entered_cnt + 1;
    if (!areset_control && response_valid_o) rsp_idx <= rsp_idx + 1;
    if (!areset_control && mem_req_o && mem_gnt) issue_idx <= issue_idx + 1;
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, %0d of %0d responses seen",
               cycles, rsp_idx, send_idx);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_reset_quiet : assert property (@(posedge ap_clk)
    $fell(areset_control) |-> (!mem_req_o && !response_valid_o && !request_prog_full_o))
    else begin ctrl_errs++; $display("Outputs not quiet after reset at %0t", $time); end
  a_idle_done : assert property (@(posedge ap_clk) disable iff (areset_control)
    idle_chk |-> done_o)
    else begin
      ctrl_errs++;
      $display("** Error at %0t: done_o expected 1 got %b", $time, $sampled(done_o));
    end
  a_busy_done : assert property (@(posedge ap_clk) disable iff (areset_control)
    (busy && $past(busy) && $past(busy, 2)) |-> !done_o)
    else begin
      ctrl_errs++;
      $display("** Error at %0t: done_o expected 0 got %b", $time, $sampled(done_o));
    end
  a_no_desc : assert property (@(posedge ap_clk) disable iff (areset_control)
    !desc_given |-> !mem_req_o)
    else begin ctrl_errs++; $display("Request issued before any descriptor at %0t", $time); end
  a_ready_low : assert property (@(posedge ap_clk) disable iff (areset_control)
    !response_ready_i |-> !mem_req_o)
    else begin ctrl_errs++; $display("Request issued while ready low at %0t", $time); end
  // Queue occupancy is pushes seen minus grants seen
  a_prog_full : assert property (@(posedge ap_clk) disable iff (areset_control)
    request_prog_full_o == ((entered_cnt - issue_idx) >= 12))
    else begin
      ctrl_errs++;
      $display("** Error at %0t: request_prog_full_o expected %b got %b", $time,
               ($sampled(entered_cnt) - $sampled(issue_idx)) >= 12,
               $sampled(request_prog_full_o));
    end

  // Issue side, compared on each grant
  a_addr : assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_req_o && mem_gnt) |-> (mem_addr_o == exp_addr[issue_idx]))
    else begin
      addr_errs++;
      $display("** Error at %0t: mem_addr_o expected %h got %h", $time,
               $sampled(exp_addr[issue_idx]), $sampled(mem_addr_o));
    end
  a_we : assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_req_o && mem_gnt) |-> (mem_we_o == (exp_cmd[issue_idx] == 2'd2)))
    else begin
      data_errs++;
      $display("** Error at %0t: mem_we_o expected %b got %b", $time,
               $sampled(exp_cmd[issue_idx]) == 2'd2, $sampled(mem_we_o));
    end
  a_wdata : assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_req_o && mem_gnt && mem_we_o) |-> (mem_wdata_o == exp_wdata[issue_idx]))
    else begin
      data_errs++;
      $display("** Error at %0t: mem_wdata_o expected %h got %h", $time,
               $sampled(exp_wdata[issue_idx]), $sampled(mem_wdata_o));
    end
  a_be : assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_req_o && mem_gnt) |-> (mem_be_o == exp_be[issue_idx]))
    else begin
      data_errs++;
      $display("** Error at %0t: mem_be_o expected %h got %h", $time,
               $sampled(exp_be[issue_idx]), $sampled(mem_be_o));
    end

  // Response side
  a_rsp_timing : assert property (@(posedge ap_clk) disable iff (areset_control)
    response_valid_o == $past(mem_rsp_valid))
    else begin
      rsp_errs++;
      $display("** Error at %0t: response_valid_o expected %b got %b", $time,
               !$sampled(response_valid_o), $sampled(response_valid_o));
    end
  a_rsp_tag : assert property (@(posedge ap_clk) disable iff (areset_control)
    response_valid_o |-> (response_tag_o == exp_tag[rsp_idx] &&
                          response_cmd_o == exp_cmd[rsp_idx]))
    else begin
      rsp_errs++;
      $display("** Error at %0t: response_tag_o/cmd expected %h/%0d got %h/%0d", $time,
               $sampled(exp_tag[rsp_idx]), $sampled(exp_cmd[rsp_idx]),
               $sampled(response_tag_o), $sampled(response_cmd_o));
    end
  a_rsp_data : assert property (@(posedge ap_clk) disable iff (areset_control)
    response_valid_o |-> (response_rdata_o == exp_rdata[rsp_idx]))
    else begin
      rsp_errs++;
      $display("** Error at %0t: response_rdata_o expected %h got %h", $time,
               $sampled(exp_rdata[rsp_idx]), $sampled(response_rdata_o));
    end

  // --------------------------------------------------
  // Stimulus tasks, called 1 ns after an edge
  // --------------------------------------------------
  task automatic send_req(input logic [1:0] cmd);
    logic [23:0] off;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] wd;
    logic [3:0]  st;
    off  = 24'($random(seed)) & 24'h3f;       // Small range, words get reused
    wd   = $random(seed);
    st   = 4'($random(seed));
    addr = BASE + ({8'h00, off} << 2);
    word = shadow.exists(addr) ? shadow[addr] : (addr ^ FILL_KEY);
    request_valid_i  = 1'b1;
    request_cmd_i    = cmd;
    request_offset_i = off;
    request_wdata_i  = wd;
    request_strb_i   = st;
    request_tag_i    = 8'($random(seed));
    exp_addr[send_idx]  = addr;
    exp_cmd[send_idx]   = cmd;
    exp_tag[send_idx]   = request_tag_i;
    exp_wdata[send_idx] = wd;
    exp_be[send_idx]    = (cmd == 2'd2) ? st : 4'h0;
    if (cmd == 2'd2) begin
      for (int b = 0; b < 4; b++) begin
        if (st[b]) word[8*b +: 8] = wd[8*b +: 8];
      end
      shadow[addr] = word;
      exp_rdata[send_idx] = '0;              // Writes answer with zero
    end
    else begin
      exp_rdata[send_idx] = word;
    end
    send_idx++;
    @(posedge ap_clk);
    #1;
    request_valid_i = 1'b0;
  endtask

  task automatic give_descriptor();
    descriptor_valid_i = 1'b1;
    descriptor_base_i  = BASE;
    desc_given         = 1'b1;
    @(posedge ap_clk);
    #1;
    descriptor_valid_i = 1'b0;
  endtask

  task automatic apply_reset();
    areset_control = 1'b1;
    repeat (10) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
  endtask

  // Drain, then watch done while idle
  task automatic drain_and_idle();
    while (rsp_idx != send_idx) @(posedge ap_clk);
    repeat (4) @(posedge ap_clk);
    #1;
    idle_chk = 1'b1;
    repeat (5) @(posedge ap_clk);
    #1;
    idle_chk = 1'b0;
  endtask

  function automatic logic [1:0] rand_cmd();
    return ($random(seed) & 1) ? 2'd2 : 2'd1;
  endfunction

  initial begin
    seed = 27133;
    {descriptor_valid_i, request_valid_i, request_cmd_i, request_offset_i} = '0;
    {descriptor_base_i, request_wdata_i, request_strb_i, request_tag_i} = '0;
    response_ready_i = 1'b1;
    {send_idx, issue_idx, rsp_idx, entered_cnt, cycles} = '0;
    {addr_errs, data_errs, rsp_errs, ctrl_errs} = '0;
    {valid_d1, valid_d2, desc_given, idle_chk} = '0;
    areset_control = 1'b1;
    #1;
    apply_reset();
    repeat (8) @(posedge ap_clk);
    #1;
    idle_chk = 1'b1;                         // Idle after reset
    repeat (4) @(posedge ap_clk);
    #1;
    idle_chk = 1'b0;

    // Base register keeps its value across a second reset
    give_descriptor();
    desc_given = 1'b0;
    apply_reset();

    // Queued without a descriptor
    for (int i = 0; i < 6; i++) send_req(rand_cmd());
    repeat (15) @(posedge ap_clk);
    #1;
    give_descriptor();
    drain_and_idle();

    // Random traffic, sender honours prog full
    for (int i = 0; i < 40; i++) begin
      while (request_prog_full_o) begin
        @(posedge ap_clk);
        #1;
      end
      send_req(rand_cmd());
      if (($random(seed) & 3) == 0) begin
        @(posedge ap_clk);
        #1;
      end
    end
    drain_and_idle();

    // Back-pressure, queue fills past the threshold
    response_ready_i = 1'b0;
    for (int i = 0; i < 14; i++) send_req(rand_cmd());
    repeat (16) @(posedge ap_clk);          // Queue sits above the threshold
    #1;
    response_ready_i = 1'b1;
    drain_and_idle();

    $display("Errors: address %0d, data %0d, response %0d, control %0d",
             addr_errs, data_errs, rsp_errs, ctrl_errs);
    if (addr_errs + data_errs + rsp_errs + ctrl_errs == 0 && rsp_idx == NUM_REQ) begin
      $display("TESTBENCH PASSED");
    end
    else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_mem_port
